// ==== rtl/board_pkg.sv ====
`default_nettype none

package board_pkg;

  // One PS/2 frame, start bit at the bottom after eleven right shifts
  typedef union packed {
    logic [10:0] raw;
    struct packed {
      logic       stop;
      logic       parity;
      logic [7:0] data;
      logic       start;
    } fields;
  } ps2_frame_t;

  // Horizontal periods in clocks
  localparam int H_ACTIVE = 64;
  localparam int H_FRONT  = 4;
  localparam int H_SYNC   = 8;
  localparam int H_BACK   = 4;
  localparam int H_SYNC_START = H_ACTIVE + H_FRONT;
  localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;

  // Vertical periods in lines
  localparam int V_ACTIVE = 48;
  localparam int V_FRONT  = 2;
  localparam int V_SYNC   = 2;
  localparam int V_BACK   = 2;
  localparam int V_SYNC_START = V_ACTIVE + V_FRONT;
  localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

  // Pixels per displayed code bit
  localparam int BAR_WIDTH = 8;

  // SOS blink, one pattern bit every 2^21 clocks
  localparam int BLINK_STEP_BITS  = 21;
  localparam int BLINK_INDEX_BITS = 5;
  localparam logic [31:0] BLINK_PATTERN = 32'b101010001110111011100010101;

  // Keyboard prefix bytes
  localparam logic [7:0] SC_BREAK  = 8'hF0;
  localparam logic [7:0] SC_EXTEND = 8'hE0;

  // PS/2 input conditioning
  localparam int PS2_SYNC_STAGES  = 2;
  localparam int PS2_STALL_CYCLES = 1024;

endpackage

`default_nettype wire

// ==== rtl/ps2_receiver.sv ====
`default_nettype none

module ps2_receiver (
  input  logic       CLK_16mhz,
  input  logic       arst_n,
  input  logic       ps2_clk,
  input  logic       ps2_data,
  output logic       byte_strobe,
  output logic [7:0] byte_data,
  output logic       frame_error
);

  localparam int SYNC_TOP = board_pkg::PS2_SYNC_STAGES - 1;

  logic [SYNC_TOP:0] clk_sync;
  logic [SYNC_TOP:0] data_sync;
  logic              clk_prev;
  logic              clk_fall;
  logic [3:0]        bit_cnt;
  logic [$clog2(board_pkg::PS2_STALL_CYCLES)-1:0] stall_cnt;
  logic              stalled;
  logic              last_bit;
  logic              frame_ok;

  board_pkg::ps2_frame_t frame;
  board_pkg::ps2_frame_t frame_next;

  // Both keyboard lines idle high
  always_ff @(posedge CLK_16mhz or negedge arst_n) begin
    if (!arst_n) begin
      clk_sync  <= '1;
      data_sync <= '1;
      clk_prev  <= 1'b1;
    end else begin
      clk_sync  <= {clk_sync[SYNC_TOP-1:0], ps2_clk};
      data_sync <= {data_sync[SYNC_TOP-1:0], ps2_data};
      clk_prev  <= clk_sync[SYNC_TOP];
    end
  end

  assign clk_fall = clk_prev & ~clk_sync[SYNC_TOP];
  assign last_bit = (bit_cnt == 4'd10);
  assign stalled  = (stall_cnt == ($bits(stall_cnt))'(board_pkg::PS2_STALL_CYCLES - 1));

  // Bits arrive LSB first, so new bits enter at the top
  always_comb begin
    frame_next.raw = {data_sync[SYNC_TOP], frame.raw[10:1]};
  end

  // Start low, stop high, odd parity over data and parity
  assign frame_ok = (frame_next.fields.start == 1'b0) &&
                    (frame_next.fields.stop == 1'b1) &&
                    (^{frame_next.fields.data, frame_next.fields.parity} == 1'b1);

  always_ff @(posedge CLK_16mhz) begin
    if (clk_fall) begin
      frame <= frame_next;
    end
    if (clk_fall && last_bit) begin
      byte_data <= frame_next.fields.data;
    end
  end

  always_ff @(posedge CLK_16mhz or negedge arst_n) begin
    if (!arst_n) begin
      bit_cnt     <= 4'd0;
      stall_cnt   <= '0;
      byte_strobe <= 1'b0;
      frame_error <= 1'b0;
    end else begin
      byte_strobe <= 1'b0;
      frame_error <= 1'b0;

      if (clk_fall) begin
        if (last_bit) begin
          bit_cnt     <= 4'd0;
          byte_strobe <= frame_ok;
          frame_error <= ~frame_ok;
        end else begin
          bit_cnt <= bit_cnt + 4'd1;
        end
      end else if (stalled) begin
        // Keyboard went quiet mid frame, drop the partial bits
        bit_cnt <= 4'd0;
      end

      // Only counts while a frame is open and the clock sits high
      if (clk_fall || bit_cnt == 4'd0 || !clk_sync[SYNC_TOP] || stalled) begin
        stall_cnt <= '0;
      end else begin
        stall_cnt <= stall_cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/scan_code_tracker.sv ====
`default_nettype none

module scan_code_tracker (
  input  logic       CLK_16mhz,
  input  logic       arst_n,
  input  logic       byte_strobe,
  input  logic [7:0] byte_data,
  input  logic       frame_error,
  output logic [7:0] key_code
);

  // Set after a break prefix, the following byte is the released key
  logic release_pending;
  logic is_break;
  logic is_extend;

  assign is_break  = (byte_data == board_pkg::SC_BREAK);
  assign is_extend = (byte_data == board_pkg::SC_EXTEND);

  always_ff @(posedge CLK_16mhz or negedge arst_n) begin
    if (!arst_n) begin
      release_pending <= 1'b0;
      key_code        <= 8'h00;
    end else if (frame_error) begin
      // A lost byte may have been the release target
      release_pending <= 1'b0;
    end else if (byte_strobe) begin
      if (release_pending) begin
        release_pending <= 1'b0;
      end else if (is_break) begin
        release_pending <= 1'b1;
      end else if (!is_extend) begin
        key_code <= byte_data;
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/video_timing.sv ====
`default_nettype none

module video_timing (
  input  logic       CLK_16mhz,
  input  logic       arst_n,
  output logic [6:0] h_count,
  output logic [5:0] v_count,
  output logic       active,
  output logic       hsync,
  output logic       vsync
);

  logic line_end;
  logic frame_end;
  logic h_in_sync;
  logic v_in_sync;

  assign line_end  = (h_count == 7'(board_pkg::H_TOTAL - 1));
  assign frame_end = (v_count == 6'(board_pkg::V_TOTAL - 1));

  // Sync windows start right after the front porch
  assign h_in_sync = (h_count >= 7'(board_pkg::H_SYNC_START)) &&
                     (h_count < 7'(board_pkg::H_SYNC_START + board_pkg::H_SYNC));
  assign v_in_sync = (v_count >= 6'(board_pkg::V_SYNC_START)) &&
                     (v_count < 6'(board_pkg::V_SYNC_START + board_pkg::V_SYNC));

  always_ff @(posedge CLK_16mhz or negedge arst_n) begin
    if (!arst_n) begin
      h_count <= 7'd0;
      v_count <= 6'd0;
    end else if (line_end) begin
      h_count <= 7'd0;
      if (frame_end) begin
        v_count <= 6'd0;
      end else begin
        v_count <= v_count + 6'd1;
      end
    end else begin
      h_count <= h_count + 7'd1;
    end
  end

  // Registered so they line up with the renderer's pixel register
  always_ff @(posedge CLK_16mhz or negedge arst_n) begin
    if (!arst_n) begin
      hsync <= 1'b1;
      vsync <= 1'b1;
    end else begin
      hsync <= ~h_in_sync;
      vsync <= ~v_in_sync;
    end
  end

  assign active = (h_count < 7'(board_pkg::H_ACTIVE)) &&
                  (v_count < 6'(board_pkg::V_ACTIVE));

endmodule

`default_nettype wire

// ==== rtl/code_bar_renderer.sv ====
`default_nettype none

module code_bar_renderer (
  input  logic       CLK_16mhz,
  input  logic       arst_n,
  input  logic [6:0] h_count,
  input  logic       active,
  input  logic [7:0] key_code,
  output logic       vga_pixel
);

  // Bar 0 is the leftmost and shows the MSB
  logic [2:0] bar_idx;
  logic [2:0] bit_sel;
  logic       code_bit;

  // Out of range past the active width, but blanked there anyway
  assign bar_idx  = 3'(h_count / 7'(board_pkg::BAR_WIDTH));
  assign bit_sel  = 3'd7 - bar_idx;
  assign code_bit = key_code[bit_sel];

  always_ff @(posedge CLK_16mhz or negedge arst_n) begin
    if (!arst_n) begin
      vga_pixel <= 1'b0;
    end else begin
      vga_pixel <= active & code_bit;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/sos_blinker.sv ====
`default_nettype none

module sos_blinker (
  input  logic CLK_16mhz,
  input  logic arst_n,
  output logic led
);

  localparam int CNT_BITS = board_pkg::BLINK_STEP_BITS + board_pkg::BLINK_INDEX_BITS;

  logic [CNT_BITS-1:0]                   blink_cnt;
  logic [board_pkg::BLINK_INDEX_BITS-1:0] pattern_idx;

  always_ff @(posedge CLK_16mhz or negedge arst_n) begin
    if (!arst_n) begin
      blink_cnt <= '0;
    end else begin
      blink_cnt <= blink_cnt + 1'b1;
    end
  end

  // Upper counter bits walk through the pattern
  assign pattern_idx = blink_cnt[CNT_BITS-1:board_pkg::BLINK_STEP_BITS];
  assign led         = board_pkg::BLINK_PATTERN[pattern_idx];

endmodule

`default_nettype wire

// ==== rtl/board_top.sv ====
`default_nettype none

module board_top (
  input  logic CLK_16mhz,
  input  logic arst_n,
  input  logic ps2_clk,
  input  logic ps2_data,
  output logic hsync,
  output logic vsync,
  output logic vga_pixel,
  output logic led
);

  // Keyboard path
  logic       byte_strobe;
  logic [7:0] byte_data;
  logic       frame_error;
  logic [7:0] key_code;

  // Video path
  logic [6:0] h_count;
  logic       active;

  ps2_receiver u_ps2_receiver (
    .CLK_16mhz   (CLK_16mhz),
    .arst_n      (arst_n),
    .ps2_clk     (ps2_clk),
    .ps2_data    (ps2_data),
    .byte_strobe (byte_strobe),
    .byte_data   (byte_data),
    .frame_error (frame_error)
  );

  scan_code_tracker u_scan_code_tracker (
    .CLK_16mhz   (CLK_16mhz),
    .arst_n      (arst_n),
    .byte_strobe (byte_strobe),
    .byte_data   (byte_data),
    .frame_error (frame_error),
    .key_code    (key_code)
  );

  // Line number is folded into active, the renderer needs no v_count
  video_timing u_video_timing (
    .CLK_16mhz (CLK_16mhz),
    .arst_n    (arst_n),
    .h_count   (h_count),
    .v_count   (),
    .active    (active),
    .hsync     (hsync),
    .vsync     (vsync)
  );

  code_bar_renderer u_code_bar_renderer (
    .CLK_16mhz (CLK_16mhz),
    .arst_n    (arst_n),
    .h_count   (h_count),
    .active    (active),
    .key_code  (key_code),
    .vga_pixel (vga_pixel)
  );

  // Status LED, shows the design is loaded and clocked
  sos_blinker u_sos_blinker (
    .CLK_16mhz (CLK_16mhz),
    .arst_n    (arst_n),
    .led       (led)
  );

endmodule

`default_nettype wire

// ==== sim/board_assertions.sv ====
`default_nettype none

module board_assertions (
  input logic CLK_16mhz,
  input logic arst_n,
  input logic ps2_clk,
  input logic byte_strobe,
  input logic frame_error,
  input logic hsync,
  input logic active,
  input logic vga_pixel,
  input logic led
);

  // Read by the testbench at the end of the run
  int failures = 0;

  logic [7:0] hsync_low;
  logic [board_pkg::BLINK_STEP_BITS+board_pkg::BLINK_INDEX_BITS-1:0] blink_ref;

  // Length of the current hsync low pulse
  always_ff @(posedge CLK_16mhz or negedge arst_n) begin
    if (!arst_n) begin
      hsync_low <= 8'd0;
    end else if (hsync) begin
      hsync_low <= 8'd0;
    end else begin
      hsync_low <= hsync_low + 8'd1;
    end
  end

  // Reference blink counter, runs in step with the blinker
  always_ff @(posedge CLK_16mhz or negedge arst_n) begin
    if (!arst_n) begin
      blink_ref <= '0;
    end else begin
      blink_ref <= blink_ref + 1'b1;
    end
  end

  strobe_exclusive: assert property (@(posedge CLK_16mhz) disable iff (!arst_n)
    !(byte_strobe && frame_error))
    else begin
      failures++;
      $error("byte_strobe and frame_error high together");
    end

  // Stop bit falls PS2_SYNC_STAGES+1 cycles before the strobe
  strobe_latency: assert property (@(posedge CLK_16mhz) disable iff (!arst_n)
    (byte_strobe || frame_error) |->
      ($past(ps2_clk, board_pkg::PS2_SYNC_STAGES + 2) &&
       !$past(ps2_clk, board_pkg::PS2_SYNC_STAGES + 1)))
    else begin
      failures++;
      $error("receiver strobe not aligned to the ps2_clk falling edge");
    end

  hsync_width: assert property (@(posedge CLK_16mhz) disable iff (!arst_n)
    $rose(hsync) |-> (hsync_low == 8'(board_pkg::H_SYNC)))
    else begin
      failures++;
      $error("hsync low for %0d cycles", $sampled(hsync_low));
    end

  pixel_blanked: assert property (@(posedge CLK_16mhz) disable iff (!arst_n)
    !active |=> !vga_pixel)
    else begin
      failures++;
      $error("vga_pixel high outside the active area");
    end

  led_pattern: assert property (@(posedge CLK_16mhz) disable iff (!arst_n)
    led == board_pkg::BLINK_PATTERN[blink_ref[board_pkg::BLINK_STEP_BITS +:
                                              board_pkg::BLINK_INDEX_BITS]])
    else begin
      failures++;
      $error("led does not follow the SOS pattern");
    end

endmodule

bind board_top board_assertions u_board_assertions (.*);

`default_nettype wire

// ==== sim/tb_board_top.sv ====
`default_nettype none

module tb_board_top;

  localparam int CLK_PERIOD    = 4;
  localparam int HALF_BIT_CLKS = 8;
  localparam int NUM_ROWS      = 9;
  localparam int SAMPLE_LINE   = 10;
  localparam int FRAME_CLKS    = board_pkg::H_TOTAL * board_pkg::V_TOTAL;
  localparam int WATCHDOG_CLKS = NUM_ROWS * (FRAME_CLKS + 40 * 16) + 10 * FRAME_CLKS;

  logic CLK_16mhz;
  logic arst_n;
  logic ps2_clk;
  logic ps2_data;
  logic hsync;
  logic vsync;
  logic vga_pixel;
  logic led;

  logic [31:0] rng_state = 32'd2930;

  // Stimulus table, byte 0 sits in the top eight bits of row_bytes
  string       row_name   [NUM_ROWS];
  int          row_len    [NUM_ROWS];
  logic [23:0] row_bytes  [NUM_ROWS];
  logic [2:0]  row_bad    [NUM_ROWS];
  logic [7:0]  row_expect [NUM_ROWS];

  board_top UUT (
    .CLK_16mhz (CLK_16mhz),
    .arst_n    (arst_n),
    .ps2_clk   (ps2_clk),
    .ps2_data  (ps2_data),
    .hsync     (hsync),
    .vsync     (vsync),
    .vga_pixel (vga_pixel),
    .led       (led)
  );

  initial begin
    CLK_16mhz = 1'b0;
    forever #(CLK_PERIOD / 2) CLK_16mhz = ~CLK_16mhz;
  end

  initial begin
    #(WATCHDOG_CLKS * CLK_PERIOD);
    $display("Timeout: the run took longer than the tests allow");
    $display("TEST FAIL");
    $fatal(1, "watchdog expired");
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic set_row(input int idx, input string name, input int len,
                         input logic [23:0] bytes, input logic [2:0] bad,
                         input logic [7:0] expected);
    row_name[idx]   = name;
    row_len[idx]    = len;
    row_bytes[idx]  = bytes;
    row_bad[idx]    = bad;
    row_expect[idx] = expected;
  endtask

  task automatic load_table();
    // idx  name          len  bytes        bad     expected key_code
    set_row(0, "reset",      0, 24'h000000, 3'b000, 8'h00);
    set_row(1, "make_1c",    1, 24'h1C0000, 3'b000, 8'h1C);
    set_row(2, "make_32",    1, 24'h320000, 3'b000, 8'h32);
    set_row(3, "break_1c",   2, 24'hF01C00, 3'b000, 8'h32);
    set_row(4, "ext_74",     2, 24'hE07400, 3'b000, 8'h74);
    set_row(5, "bad_parity", 1, 24'h5A0000, 3'b001, 8'h74);
    set_row(6, "good_after", 1, 24'h5A0000, 3'b000, 8'h5A);
    set_row(7, "ext_break",  3, 24'hE0F074, 3'b000, 8'h5A);
    // Lost byte after F0 cancels the release
    set_row(8, "break_lost", 3, 24'hF03321, 3'b010, 8'h21);
  endtask

  // Waits n rising edges, then steps just past the last one
  task automatic idle_clocks(input int n);
    repeat (n) @(posedge CLK_16mhz);
    #1;
  endtask

  task automatic skip_clocks(input int n);
    repeat (n) @(negedge CLK_16mhz);
  endtask

  task automatic send_byte(input logic [7:0] data, input logic bad_parity);
    board_pkg::ps2_frame_t frame;
    frame.fields.start  = 1'b0;
    frame.fields.data   = data;
    frame.fields.parity = ~(^data) ^ bad_parity;
    frame.fields.stop   = 1'b1;
    for (int i = 0; i < 11; i++) begin
      ps2_data = frame.raw[i];
      idle_clocks(HALF_BIT_CLKS);
      ps2_clk = 1'b0;
      idle_clocks(HALF_BIT_CLKS);
      ps2_clk = 1'b1;
    end
    ps2_data = 1'b1;
    rng_state = xorshift32(rng_state);
    idle_clocks(4 + int'(rng_state % 28));
  endtask

  // Counts falling clock edges until the chosen sync line reaches level
  task automatic count_until(input logic use_vsync, input logic level, output int n);
    n = 1;
    @(negedge CLK_16mhz);
    while ((use_vsync ? vsync : hsync) !== level) begin
      @(negedge CLK_16mhz);
      n++;
    end
  endtask

  // Ends on column 0 of the first vsync line
  task automatic wait_frame_start();
    int n;
    count_until(1'b1, 1'b1, n);
    count_until(1'b1, 1'b0, n);
  endtask

  task automatic check_code(input string name, input logic [7:0] expected,
                            input logic [7:0] actual);
    if (actual !== expected) begin
      $display("** Error: %s expected %02h actual %02h", name, expected, actual);
      $display("TEST FAIL");
      $fatal(1, "code mismatch in %s", name);
    end
  endtask

  task automatic check_level(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("** Error: %s expected %b actual %b", name, expected, actual);
      $display("TEST FAIL");
      $fatal(1, "level mismatch in %s", name);
    end
  endtask

  task automatic check_count(input string name, input int expected, input int actual);
    if (actual != expected) begin
      $display("** Error: %s expected %0d actual %0d", name, expected, actual);
      $display("TEST FAIL");
      $fatal(1, "timing mismatch in %s", name);
    end
  endtask

  task automatic check_frame_timing();
    int low_n;
    int high_n;
    wait_frame_start();
    for (int f = 0; f < 2; f++) begin
      count_until(1'b1, 1'b1, low_n);
      count_until(1'b1, 1'b0, high_n);
      check_count("vsync_width", board_pkg::V_SYNC * board_pkg::H_TOTAL, low_n);
      check_count("vsync_period", FRAME_CLKS, low_n + high_n);
    end
    count_until(1'b0, 1'b0, high_n);
    check_count("hsync_start", board_pkg::H_ACTIVE + board_pkg::H_FRONT, high_n);
    for (int l = 0; l < board_pkg::V_TOTAL; l++) begin
      count_until(1'b0, 1'b1, low_n);
      count_until(1'b0, 1'b0, high_n);
      check_count("hsync_width", board_pkg::H_SYNC, low_n);
      check_count("line_period", board_pkg::H_TOTAL, low_n + high_n);
    end
  endtask

  // Samples bar centres and some blanking columns of the sample line
  task automatic read_bars(input string name, output logic [7:0] shown);
    int n;
    int pos;
    int col;
    shown = 8'h00;
    wait_frame_start();
    repeat (board_pkg::V_TOTAL - board_pkg::V_SYNC_START + SAMPLE_LINE) begin
      count_until(1'b0, 1'b1, n);
      count_until(1'b0, 1'b0, n);
    end
    // Sitting on the hsync fall of the line above, relative to the sample line
    pos = board_pkg::H_SYNC_START - board_pkg::H_TOTAL;
    for (int b = 0; b < 8; b++) begin
      col = b * board_pkg::BAR_WIDTH + board_pkg::BAR_WIDTH / 2;
      skip_clocks(col - pos);
      pos = col;
      shown[7 - b] = vga_pixel;
    end
    for (col = board_pkg::H_ACTIVE; col < board_pkg::H_TOTAL; col += 5) begin
      skip_clocks(col - pos);
      pos = col;
      check_level({name, "_blank"}, 1'b0, vga_pixel);
    end
  endtask

  initial begin
    logic [7:0] shown;
    arst_n   = 1'b0;
    ps2_clk  = 1'b1;
    ps2_data = 1'b1;
    load_table();
    idle_clocks(16);
    arst_n = 1'b1;

    @(negedge CLK_16mhz);
    check_level("led_after_reset", 1'b1, led);
    check_level("hsync_after_reset", 1'b1, hsync);
    check_level("vsync_after_reset", 1'b1, vsync);

    check_frame_timing();

    for (int r = 0; r < NUM_ROWS; r++) begin
      idle_clocks(1);
      for (int k = 0; k < row_len[r]; k++) begin
        send_byte(row_bytes[r][23 - 8 * k -: 8], row_bad[r][k]);
      end
      read_bars(row_name[r], shown);
      check_code(row_name[r], row_expect[r], shown);
    end

    check_level("led_at_end", 1'b1, led);

    if (UUT.u_board_assertions.failures == 0) begin
      $display("TEST PASS");
      $finish;
    end else begin
      $display("Assertion failures: %0d", UUT.u_board_assertions.failures);
      $display("TEST FAIL");
      $fatal(1, "assertions failed");
    end
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
rtl/board_pkg.sv
rtl/ps2_receiver.sv
rtl/scan_code_tracker.sv
rtl/video_timing.sv
rtl/code_bar_renderer.sv
rtl/sos_blinker.sv
rtl/board_top.sv
sim/board_assertions.sv
sim/tb_board_top.sv
